/* hdl/fetch_bus_pkg.sv */
// Fetch bus types
// Request and response words of the instruction fetch bus, shared by the
// prefetch unit and the memory model on the other side of the bus
`default_nettype none

package fetch_bus_pkg;

  //////////////////////////////////////////////////
  // Request channel
  //////////////////////////////////////////////////

  // One word read per accepted request
  // Handshake is trans_valid/trans_ready outside the struct
  typedef struct packed {
    // Word aligned, bits [1:0] always zero
    logic [31:0] addr;
    // Read of a pointer table entry, not an instruction
    logic        ptr;
  } bus_req_t;

  //////////////////////////////////////////////////
  // Response channel
  //////////////////////////////////////////////////

  // One response per accepted request, returned in order
  // Qualified by resp_valid, no back-pressure on this side
  typedef struct packed {
    logic [31:0] rdata;
    // Bus error, passed on with the word
    logic        err;
  } bus_resp_t;

endpackage

`default_nettype wire

/* hdl/prefetch_pkg.sv */
// Prefetch types
// Controller states and the word formats handled inside the prefetch unit
`default_nettype none

package prefetch_pkg;

  //////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Out of reset, waiting for the first branch
    WAIT_BRANCH = 2'b00,
    // Streaming sequential words
    RUN         = 2'b01,
    // Pointer table read not yet accepted
    PTR_ISSUE   = 2'b10,
    // Pointer table read accepted, waiting for its data
    PTR_WAIT    = 2'b11
  } prefetch_state_e;

  //////////////////////////////////////////////////
  // Fetched word
  //////////////////////////////////////////////////

  // Same 32 bits, seen as an instruction or as a table entry
  typedef union packed {
    struct packed {
      logic [31:0] raw;
    } instr;
    // Table entry holds a word index in its low 30 bits
    struct packed {
      logic [1:0]  rsvd;
      logic [29:0] target;
    } ptr;
  } fetch_word_u;

  // Entry handed to the core
  typedef struct packed {
    logic [31:0] addr;
    fetch_word_u word;
    logic        err;
  } fetch_instr_t;

endpackage

`default_nettype wire

/* hdl/prefetch_ctrl_fsm.sv */
// Prefetch controller
// Tracks the fetch mode, decides when a bus request may issue, and raises
// the flush and pointer load strobes
`timescale 1ns/100ps
`default_nettype none

module prefetch_ctrl_fsm #(
  // Depth of the instruction FIFO, 2 to 7 with a 3-bit count
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire                           clk,
  input  wire                           rst_n,
  // Core side
  input  wire                           branch_i,
  input  wire                           branch_ptr_i,
  // Space accounting
  input  wire                           can_issue_i,
  input  wire  [2:0]                    fifo_count_i,
  input  wire  [2:0]                    kept_in_flight_i,
  // Bus
  input  wire                           trans_ready_i,
  input  wire                           resp_valid_i,
  input  wire                           keep_resp_i,
  // Control out
  output logic                          issue_o,
  output logic                          ptr_req_o,
  output logic                          flush_o,
  output logic                          load_ptr_o,
  output prefetch_pkg::prefetch_state_e state_o
);

  import prefetch_pkg::*;

  prefetch_state_e state_q;
  prefetch_state_e state_d;
  logic [3:0]      occupancy;
  logic            room;

  // Slots taken = words buffered plus words still coming back
  assign occupancy = {1'b0, fifo_count_i} + {1'b0, kept_in_flight_i};
  assign room      = occupancy < 4'(FIFO_DEPTH);

  // Every branch empties the FIFO in its own cycle
  assign flush_o = branch_i;
  assign state_o = state_q;

  //////////////////////////////////////////////////
  // Next state and request decision
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    issue_o    = 1'b0;
    ptr_req_o  = 1'b0;
    load_ptr_o = 1'b0;

    if (branch_i) begin
      // FIFO and kept requests are both cleared this cycle,
      // so only the bus limit holds the target back
      issue_o   = can_issue_i;
      ptr_req_o = branch_ptr_i;
      if (!branch_ptr_i) begin
        state_d = RUN;
      end else if (issue_o && trans_ready_i) begin
        state_d = PTR_WAIT;
      end else begin
        state_d = PTR_ISSUE;
      end
    end else begin
      case (state_q)
        WAIT_BRANCH: begin
          // No address known yet
          state_d = WAIT_BRANCH;
        end
        RUN: begin
          issue_o = can_issue_i && room;
        end
        PTR_ISSUE: begin
          issue_o   = can_issue_i && room;
          ptr_req_o = 1'b1;
          if (issue_o && trans_ready_i) begin
            state_d = PTR_WAIT;
          end
        end
        PTR_WAIT: begin
          // Only the table read is kept here, older words are dropped
          if (resp_valid_i && keep_resp_i) begin
            load_ptr_o = 1'b1;
            state_d    = RUN;
          end
        end
        default: begin
          state_d = WAIT_BRANCH;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WAIT_BRANCH;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/prefetch_addr_gen.sv */
// Prefetch address generator
// Holds the next fetch address, loads branch and pointer targets, and keeps
// the addresses of accepted requests in order for tagging the returned words
`timescale 1ns/100ps
`default_nettype none

module prefetch_addr_gen #(
  parameter int unsigned FIFO_DEPTH      = 4,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       branch_i,
  input  wire  [31:0]               branch_addr_i,
  // Accepted sequential request
  input  wire                       step_i,
  input  wire                       load_ptr_i,
  // Kept instruction word leaves the queue
  input  wire                       pop_i,
  input  wire prefetch_pkg::fetch_word_u ptr_word_i,
  output logic [31:0]               addr_o,
  output logic [31:0]               issued_addr_o
);

  localparam int unsigned Q_DEPTH = FIFO_DEPTH + MAX_OUTSTANDING;
  localparam int unsigned Q_PTR_W = $clog2(Q_DEPTH);

  logic [31:0]        next_addr_q;
  logic [31:0]        addr_q [Q_DEPTH];
  logic [Q_PTR_W-1:0] q_wr_ptr;
  logic [Q_PTR_W-1:0] q_rd_ptr;
  logic [Q_PTR_W-1:0] q_wr_idx;

  // Wrap for a depth that need not be a power of two
  function automatic logic [Q_PTR_W-1:0] q_next(input logic [Q_PTR_W-1:0] ptr);
    if (ptr == Q_PTR_W'(Q_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Branch target goes out in the same cycle
  assign addr_o = branch_i ? branch_addr_i : next_addr_q;

  //////////////////////////////////////////////////
  // Next fetch address
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q <= '0;
    end else if (branch_i) begin
      next_addr_q <= step_i ? branch_addr_i + 32'd4 : branch_addr_i;
    end else if (load_ptr_i) begin
      // Word index to byte address
      next_addr_q <= {ptr_word_i.ptr.target, 2'b00};
    end else if (step_i) begin
      next_addr_q <= next_addr_q + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // Issued address queue
  //////////////////////////////////////////////////

  // A branch drops every older entry, its own target lands in slot 0
  assign q_wr_idx = branch_i ? '0 : q_wr_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
    end else if (branch_i) begin
      q_rd_ptr <= '0;
      q_wr_ptr <= step_i ? q_next('0) : '0;
    end else begin
      if (step_i) begin
        q_wr_ptr <= q_next(q_wr_ptr);
      end
      if (pop_i) begin
        q_rd_ptr <= q_next(q_rd_ptr);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_i) begin
      addr_q[q_wr_idx] <= addr_o;
    end
  end

  // Address of the oldest kept word still to come back
  assign issued_addr_o = addr_q[q_rd_ptr];

endmodule

`default_nettype wire

/* hdl/outstanding_counter.sv */
// Outstanding request counter
// Counts bus reads in flight and how many of them belong to a stream
// that a branch has abandoned
`timescale 1ns/100ps
`default_nettype none

module outstanding_counter #(
  // Bus read limit, 1 to 7
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        accept_i,
  input  wire        resp_valid_i,
  input  wire        flush_i,
  output logic       can_issue_o,
  output logic       keep_resp_o,
  output logic [2:0] kept_in_flight_o
);

  logic [2:0] in_flight_q;
  logic [2:0] in_flight_left;
  logic [2:0] in_flight_d;
  logic [2:0] discard_q;
  logic [2:0] discard_d;

  // In flight after this cycle's response, before a new acceptance
  assign in_flight_left = in_flight_q - {2'b00, resp_valid_i};
  assign in_flight_d    = in_flight_left + {2'b00, accept_i};

  always_comb begin
    discard_d = discard_q;
    if (flush_i) begin
      // Whatever is still out belongs to the old stream
      discard_d = in_flight_left;
    end else if (resp_valid_i && (discard_q != 3'd0)) begin
      discard_d = discard_q - 3'd1;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Old responses come back first, being in order
  assign keep_resp_o      = (discard_q == 3'd0);
  assign can_issue_o      = in_flight_q < 3'(MAX_OUTSTANDING);
  assign kept_in_flight_o = in_flight_q - discard_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight_q <= 3'd0;
      discard_q   <= 3'd0;
    end else begin
      in_flight_q <= in_flight_d;
      discard_q   <= discard_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_fifo.sv */
// Instruction FIFO
// In-order buffer between the bus responses and the core, emptied in a
// single cycle on a branch
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo #(
  // 2 to 7 entries, the count is 3 bits wide
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        wr_i,
  input  wire prefetch_pkg::fetch_instr_t wr_data_i,
  input  wire                        flush_i,
  input  wire                        rd_i,
  output prefetch_pkg::fetch_instr_t rd_data_o,
  output logic                       empty_o,
  output logic [2:0]                 count_o
);

  import prefetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  fetch_instr_t     mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [2:0]       count_q;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Slots are reserved at issue time, a write never meets a full FIFO
  // Flush wins over a write in the same cycle
  assign do_wr = wr_i && !flush_i;
  assign do_rd = rd_i && (count_q != 3'd0);

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 3'd0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 3'd0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_rd) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 3'd1;
        2'b01:   count_q <= count_q - 3'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Head entry shows through while not empty
  assign rd_data_o = mem_q[rd_ptr_q];
  assign empty_o   = (count_q == 3'd0);
  assign count_o   = count_q;

endmodule

`default_nettype wire

/* hdl/prefetch_unit.sv */
// Instruction prefetch unit
// Fetches word-aligned instructions ahead of the core, bounded by the bus
// read limit and the free space of the instruction FIFO
`timescale 1ns/100ps
`default_nettype none

module prefetch_unit #(
  parameter int unsigned FIFO_DEPTH      = 4,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  wire                             clk,
  input  wire                             rst_n,
  // Core side
  input  wire                             branch_i,
  input  wire                             branch_ptr_i,
  input  wire  [31:0]                     branch_addr_i,
  output logic                            instr_valid_o,
  input  wire                             instr_ready_i,
  output prefetch_pkg::fetch_instr_t      instr_o,
  // Bus side
  output logic                            trans_valid_o,
  input  wire                             trans_ready_i,
  output fetch_bus_pkg::bus_req_t         trans_o,
  input  wire                             resp_valid_i,
  input  wire fetch_bus_pkg::bus_resp_t   resp_i
);

  import prefetch_pkg::*;

  logic            issue;
  logic            ptr_req;
  logic            flush;
  logic            load_ptr;
  logic            can_issue;
  logic            keep_resp;
  logic            accept;
  logic            step;
  logic [2:0]      kept_in_flight;
  logic [2:0]      fifo_count;
  logic            fifo_wr;
  logic            fifo_rd;
  logic            fifo_empty;
  logic [31:0]     fetch_addr;
  logic [31:0]     issued_addr;
  prefetch_state_e state;
  fetch_word_u     resp_word;
  fetch_instr_t    fifo_wr_data;

  //////////////////////////////////////////////////
  // Glue
  //////////////////////////////////////////////////

  assign accept        = issue && trans_ready_i;
  assign step          = accept && !ptr_req;
  assign trans_valid_o = issue;
  assign trans_o       = '{addr: fetch_addr, ptr: ptr_req};

  // Kept words in RUN are instructions, the pointer word is consumed
  assign fifo_wr = resp_valid_i && keep_resp && (state == RUN);
  assign fifo_rd = instr_valid_o && instr_ready_i;

  assign resp_word.instr.raw = resp_i.rdata;
  assign fifo_wr_data        = '{addr: issued_addr, word: resp_word, err: resp_i.err};
  assign instr_valid_o       = !fifo_empty;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  prefetch_ctrl_fsm #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .branch_i(branch_i), .branch_ptr_i(branch_ptr_i),
    .can_issue_i(can_issue), .fifo_count_i(fifo_count),
    .kept_in_flight_i(kept_in_flight), .trans_ready_i(trans_ready_i),
    .resp_valid_i(resp_valid_i), .keep_resp_i(keep_resp),
    .issue_o(issue), .ptr_req_o(ptr_req), .flush_o(flush),
    .load_ptr_o(load_ptr), .state_o(state)
  );

  outstanding_counter #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_count (
    .clk(clk), .rst_n(rst_n),
    .accept_i(accept), .resp_valid_i(resp_valid_i), .flush_i(flush),
    .can_issue_o(can_issue), .keep_resp_o(keep_resp),
    .kept_in_flight_o(kept_in_flight)
  );

  prefetch_addr_gen #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_addr (
    .clk(clk), .rst_n(rst_n),
    .branch_i(branch_i), .branch_addr_i(branch_addr_i),
    .step_i(step), .load_ptr_i(load_ptr), .pop_i(fifo_wr),
    .ptr_word_i(resp_word), .addr_o(fetch_addr), .issued_addr_o(issued_addr)
  );

  fetch_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .wr_i(fifo_wr), .wr_data_i(fifo_wr_data), .flush_i(flush),
    .rd_i(fifo_rd), .rd_data_o(instr_o),
    .empty_o(fifo_empty), .count_o(fifo_count)
  );

endmodule

`default_nettype wire

/* verif/prefetch_unit_tb.sv */
// Prefetch unit testbench
// Random-latency bus memory, stalling core and branch stimulus around the
// prefetch unit, with checks on request order, delivered words and flushes
`timescale 1ns/100ps
`default_nettype none

module prefetch_unit_tb;

  import prefetch_pkg::*;
  import fetch_bus_pkg::*;

  localparam int unsigned FIFO_DEPTH      = 4;
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int          CLK_PERIOD      = 40;
  localparam logic [31:0] XOR_PATTERN     = 32'h5A5A_0000;
  localparam logic [31:0] ERR_LO          = 32'h0000_3000;
  localparam logic [31:0] ERR_HI          = 32'h0000_30FF;
  // Table entry at 0x2000, word index of 0x4400
  localparam logic [31:0] PTR_ENTRY       = 32'h0000_1100;
  // Streaming address that the table entry stands for
  localparam logic [31:0] PTR_TARGET      = 32'h0000_4400;
  // Instructions waited for over all four tests
  localparam int          TOTAL_INSTR     = 44;
  localparam int          WATCHDOG_CYCLES = TOTAL_INSTR * 12 + 200;

  logic         clk;
  logic         rst_n;
  logic         branch_i;
  logic         branch_ptr_i;
  logic [31:0]  branch_addr_i;
  logic         instr_valid_o;
  logic         instr_ready_i;
  fetch_instr_t instr_o;
  logic         trans_valid_o;
  logic         trans_ready_i;
  bus_req_t     trans_o;
  logic         resp_valid_i;
  bus_resp_t    resp_i;

  // Memory model, one entry per accepted request
  logic [31:0] mem_addr_q  [$];
  logic        mem_ptr_q   [$];
  int          mem_due_q   [$];
  int          mem_epoch_q [$];
  // Addresses expected at the core, in issue order
  logic [31:0] exp_q [$];

  int          cycle;
  int          epoch;
  int          in_flight;
  int          delivered;
  int          checks;
  int          errors;
  int          tests;
  int          err_words;
  int          ptr_requests;
  logic        seen_branch;
  logic        ptr_expected;
  logic        ptr_pending;
  logic        first_pending;
  logic [31:0] next_addr;
  logic [31:0] first_addr;
  logic        resp_ptr;
  int          resp_epoch;
  logic        branch_req;
  logic        branch_req_ptr;
  logic [31:0] branch_req_addr;

  prefetch_unit #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) UUT (
    .clk(clk), .rst_n(rst_n),
    .branch_i(branch_i), .branch_ptr_i(branch_ptr_i), .branch_addr_i(branch_addr_i),
    .instr_valid_o(instr_valid_o), .instr_ready_i(instr_ready_i), .instr_o(instr_o),
    .trans_valid_o(trans_valid_o), .trans_ready_i(trans_ready_i), .trans_o(trans_o),
    .resp_valid_i(resp_valid_i), .resp_i(resp_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR at cycle %0d: %s", cycle, what);
      errors++;
    end
  endtask

  function automatic logic in_err_range(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  //////////////////////////////////////////////////
  // Per-cycle monitor, sampled at the falling edge
  //////////////////////////////////////////////////

  task automatic monitor_cycle();
    int          n_acc;
    int          n_resp;
    logic [31:0] exp_addr;
    n_acc  = 0;
    n_resp = 0;
    if (!seen_branch && !branch_i) begin
      check_cond(!trans_valid_o && !instr_valid_o, "activity before the first branch");
    end
    if (!branch_i) begin
      check_cond(!(ptr_pending && trans_valid_o), "request valid during pointer wait");
    end
    // A delivery in a branch cycle still belongs to the old stream
    if (instr_valid_o && instr_ready_i) begin
      delivered++;
      if (exp_q.size() == 0) begin
        check_cond(1'b0, "instruction delivered with no matching request");
      end else begin
        exp_addr = exp_q.pop_front();
        check_value("instr_o.addr", instr_o.addr, exp_addr);
        check_value("instr_o.word", instr_o.word.instr.raw, exp_addr ^ XOR_PATTERN);
        check_value("instr_o.err", 32'(instr_o.err), 32'(in_err_range(exp_addr)));
        if (first_pending) begin
          check_value("first instr_o.addr", instr_o.addr, first_addr);
          first_pending = 1'b0;
        end
        if (in_err_range(exp_addr)) begin
          err_words++;
        end
      end
    end
    if (resp_valid_i) begin
      n_resp = 1;
      // Pointer data that survived every branch ends the wait
      if (resp_ptr && (resp_epoch == epoch)) begin
        ptr_pending = 1'b0;
      end
    end
    if (branch_i) begin
      seen_branch = 1'b1;
      check_value("trans_o.addr", trans_o.addr, branch_addr_i);
      check_value("trans_o.ptr", 32'(trans_o.ptr), 32'(branch_ptr_i));
      if (in_flight < MAX_OUTSTANDING) begin
        check_cond(trans_valid_o, "branch target not requested with bus room left");
      end
      epoch++;
      exp_q.delete();
      ptr_pending   = 1'b0;
      ptr_expected  = branch_ptr_i;
      next_addr     = branch_addr_i;
      first_addr    = branch_addr_i;
      first_pending = 1'b1;
    end
    if (trans_valid_o && trans_ready_i) begin
      n_acc = 1;
      check_value("trans_o.ptr", 32'(trans_o.ptr), 32'(ptr_expected));
      check_value("trans_o.addr", trans_o.addr, next_addr);
      mem_addr_q.push_back(trans_o.addr);
      mem_ptr_q.push_back(trans_o.ptr);
      mem_due_q.push_back(cycle + 1 + int'($urandom % 4));
      mem_epoch_q.push_back(epoch);
      if (ptr_expected) begin
        // Table word is a word index, streaming restarts at its byte address
        ptr_expected = 1'b0;
        ptr_pending  = 1'b1;
        ptr_requests++;
        next_addr  = PTR_TARGET;
        first_addr = next_addr;
      end else begin
        exp_q.push_back(next_addr);
        next_addr = next_addr + 32'd4;
      end
    end
    in_flight = in_flight + n_acc - n_resp;
    check_cond(in_flight <= MAX_OUTSTANDING, "too many requests in flight");
  endtask

  //////////////////////////////////////////////////
  // Input drive, just after the rising edge
  //////////////////////////////////////////////////

  task automatic drive_cycle();
    @(posedge clk);
    cycle++;
    #2;
    branch_i      = branch_req;
    branch_ptr_i  = branch_req && branch_req_ptr;
    branch_addr_i = branch_req_addr;
    branch_req    = 1'b0;
    trans_ready_i = ($urandom % 4) != 0;
    instr_ready_i = ($urandom % 4) != 0;
    resp_valid_i  = 1'b0;
    resp_i        = '0;
    // In-order answer once the front entry's latency has run out
    if ((mem_addr_q.size() != 0) && (mem_due_q[0] <= cycle)) begin
      resp_valid_i = 1'b1;
      resp_ptr     = mem_ptr_q.pop_front();
      resp_epoch   = mem_epoch_q.pop_front();
      void'(mem_due_q.pop_front());
      resp_i.err   = in_err_range(mem_addr_q[0]);
      resp_i.rdata = resp_ptr ? PTR_ENTRY : (mem_addr_q.pop_front() ^ XOR_PATTERN);
      if (resp_ptr) begin
        void'(mem_addr_q.pop_front());
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    monitor_cycle();
    drive_cycle();
  endtask

  task automatic request_branch(input logic [31:0] addr, input logic is_ptr);
    branch_req      = 1'b1;
    branch_req_addr = addr;
    branch_req_ptr  = is_ptr;
    tick();
  endtask

  task automatic wait_delivered(input int count);
    int target;
    target = delivered + count;
    while (delivered < target) begin
      tick();
    end
  endtask

  task automatic wait_in_flight();
    while (in_flight == 0) begin
      tick();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("Test %0d, %s: ok", tests, name);
    end else begin
      $display("Test %0d, %s: %0d errors", tests, name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int mark;
    void'($urandom(8));
    clk = 1'b0;
    rst_n = 1'b0;
    branch_i = 1'b0;
    branch_ptr_i = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    trans_ready_i = 1'b0;
    resp_valid_i = 1'b0;
    resp_i = '0;
    cycle = 0;
    epoch = 0;
    in_flight = 0;
    delivered = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    err_words = 0;
    ptr_requests = 0;
    resp_epoch = 0;
    seen_branch = 1'b0;
    ptr_expected = 1'b0;
    ptr_pending = 1'b0;
    first_pending = 1'b0;
    resp_ptr = 1'b0;
    next_addr = '0;
    first_addr = '0;
    branch_req_addr = '0;
    branch_req = 1'b0;
    branch_req_ptr = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle until the first branch
    repeat (4) tick();

    mark = errors;
    request_branch(32'h0000_1000, 1'b0);
    wait_delivered(16);
    report_test("sequential fetch", mark);

    mark = errors;
    request_branch(32'h0000_1800, 1'b0);
    repeat (2) tick();
    wait_in_flight();
    request_branch(32'h0000_1C00, 1'b0);
    repeat (1 + $urandom % 3) tick();
    wait_in_flight();
    request_branch(32'h0000_2400, 1'b0);
    wait_delivered(8);
    report_test("branches with responses in flight", mark);

    mark = errors;
    err_words = 0;
    request_branch(32'h0000_2FF0, 1'b0);
    wait_delivered(12);
    check_cond(err_words > 0, "no word from the error range was delivered");
    report_test("error range", mark);

    mark = errors;
    ptr_requests = 0;
    request_branch(32'h0000_2000, 1'b1);
    wait_delivered(8);
    check_cond(ptr_requests == 1, "pointer table read was not issued once");
    report_test("pointer branch", mark);

    repeat (4) tick();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* prefetch_unit.f */
hdl/fetch_bus_pkg.sv
hdl/prefetch_pkg.sv
hdl/prefetch_ctrl_fsm.sv
hdl/prefetch_addr_gen.sv
hdl/outstanding_counter.sv
hdl/fetch_fifo.sv
hdl/prefetch_unit.sv
verif/prefetch_unit_tb.sv
